//--- bench/flu_tb.sv
/*
 * Fixed-latency unit testbench
 * Random ALU, branch and multiply traffic plus CSR and flush cases,
 * checked every cycle against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

module flu_tb import flu_pkg::*; ();

    localparam logic [3:0] K_ALU    = 4'b0001;
    localparam logic [3:0] K_BRANCH = 4'b0010;
    localparam logic [3:0] K_CSR    = 4'b0100;
    localparam logic [3:0] K_MULT   = 4'b1000;
    localparam int N_ALU         = 60;
    localparam int N_BRANCH      = 60;
    localparam int N_MULT_ROUNDS = 12;
    // Three multiplies and a gap per round, plus CSR and flush cases
    localparam int N_OPS       = N_ALU + N_BRANCH + 4 * N_MULT_ROUNDS + 20;
    localparam int WATCHDOG_NS = N_OPS * 40 + 1000;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        flush_i;
    logic        alu_valid_i;
    logic        branch_valid_i;
    logic        csr_valid_i;
    logic        mult_valid_i;
    logic        csr_commit_i;
    logic        is_compressed_i;
    logic        predict_taken_i;
    fu_op_e      operator_i;
    logic [31:0] operand_a_i;
    operand_u    operand_b_i;
    logic [31:0] imm_i;
    logic [31:0] pc_i;
    logic [2:0]  trans_id_i;
    logic [31:0] flu_result_o;
    logic [2:0]  flu_trans_id_o;
    logic        flu_valid_o;
    logic        flu_ready_o;
    logic        resolve_branch_o;
    logic        branch_taken_o;
    logic        mispredict_o;
    logic [31:0] branch_target_o;
    logic [11:0] csr_addr_o;

    // Reference model state
    logic        mult_pend;
    fu_op_e      mult_op_q;
    logic [31:0] mult_a_q;
    logic [31:0] mult_b_q;
    logic [2:0]  mult_id_q;
    logic        csr_full;
    logic [31:0] lfsr_q = 32'h1775;
    int          checks = 0;
    int          errors = 0;

    flu_top #(
        .TRANS_ID_BITS (3)
    ) flu_top_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .alu_valid_i      (alu_valid_i),
        .branch_valid_i   (branch_valid_i),
        .csr_valid_i      (csr_valid_i),
        .mult_valid_i     (mult_valid_i),
        .csr_commit_i     (csr_commit_i),
        .is_compressed_i  (is_compressed_i),
        .predict_taken_i  (predict_taken_i),
        .operator_i       (operator_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .imm_i            (imm_i),
        .pc_i             (pc_i),
        .trans_id_i       (trans_id_i),
        .flu_result_o     (flu_result_o),
        .flu_trans_id_o   (flu_trans_id_o),
        .flu_valid_o      (flu_valid_o),
        .flu_ready_o      (flu_ready_o),
        .resolve_branch_o (resolve_branch_o),
        .branch_taken_o   (branch_taken_o),
        .mispredict_o     (mispredict_o),
        .branch_target_o  (branch_target_o),
        .csr_addr_o       (csr_addr_o)
    );

    always #10 clk_i = ~clk_i;

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        int unsigned k;
        val = '0;
        for (k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected value of an ALU or multiply operation
    function automatic logic [31:0] expect_result(input fu_op_e op, input logic [31:0] a,
                                                  input logic [31:0] b);
        logic [63:0] ps;
        logic [63:0] pu;
        // Sign-extended operands give the signed product in 64 bits
        ps = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        pu = {32'h0, a} * {32'h0, b};
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            SLT:     return {31'h0, $signed(a) < $signed(b)};
            SLTU:    return {31'h0, a < b};
            MUL:     return pu[31:0];
            MULH:    return ps[63:32];
            MULHU:   return pu[63:32];
            default: return 32'h0;
        endcase
    endfunction

    // Branch condition of a compare operator
    function automatic logic compare_holds(input fu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            GES:     return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Multiply in flight and CSR occupancy of the reference model
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mult_pend <= 1'b0;
            csr_full  <= 1'b0;
        end else begin
            mult_pend <= mult_valid_i & ~flush_i;
            mult_op_q <= operator_i;
            mult_a_q  <= operand_a_i;
            mult_b_q  <= operand_b_i.data;
            mult_id_q <= trans_id_i;
            csr_full  <= (csr_full | csr_valid_i) & ~(csr_commit_i | flush_i);
        end
    end

    // ----------------------------------------
    // Compare, in the middle of each cycle
    // ----------------------------------------
    always @(negedge clk_i) begin : compare
        logic        mult_wb;
        logic        cond;
        logic        exp_valid;
        logic [31:0] next_pc;
        logic [31:0] exp_res;
        logic [2:0]  exp_id;
        mult_wb   = mult_pend & ~flush_i;
        cond      = compare_holds(operator_i, operand_a_i, operand_b_i.data);
        next_pc   = pc_i + (is_compressed_i ? 32'd2 : 32'd4);
        exp_valid = alu_valid_i | branch_valid_i | csr_valid_i | mult_wb;
        // Link address unless a higher-priority result is present
        exp_res   = next_pc;
        exp_id    = trans_id_i;
        if (alu_valid_i) begin
            exp_res = expect_result(operator_i, operand_a_i, operand_b_i.data);
        end else if (csr_valid_i) begin
            exp_res = operand_a_i;
        end else if (mult_wb) begin
            exp_res = expect_result(mult_op_q, mult_a_q, mult_b_q);
            exp_id  = mult_id_q;
        end
        check_value("flu_valid_o", flu_valid_o, exp_valid);
        check_value("flu_ready_o", flu_ready_o, !csr_full);
        check_value("resolve_branch_o", resolve_branch_o, branch_valid_i);
        check_value("mispredict_o", mispredict_o,
                    branch_valid_i & (predict_taken_i != cond));
        if (exp_valid) begin
            check_value("flu_result_o", flu_result_o, exp_res);
            check_value("flu_trans_id_o", flu_trans_id_o, exp_id);
        end
        if (branch_valid_i) begin
            check_value("branch_taken_o", branch_taken_o, cond);
            check_value("branch_target_o", branch_target_o, cond ? pc_i + imm_i : next_pc);
        end
        if (csr_valid_i) begin
            check_value("csr_addr_o", csr_addr_o, operand_b_i.data[11:0]);
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic issue_op(input logic [3:0] kind, input fu_op_e op,
                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm;
        imm = rand_bits(12);
        @(posedge clk_i);
        alu_valid_i     <= kind[0];
        branch_valid_i  <= kind[1];
        csr_valid_i     <= kind[2];
        mult_valid_i    <= kind[3];
        csr_commit_i    <= 1'b0;
        flush_i         <= 1'b0;
        operator_i      <= op;
        operand_a_i     <= a;
        operand_b_i     <= b;
        // Even, sign-extended branch offset
        imm_i           <= {{20{imm[11]}}, imm[11:1], 1'b0};
        pc_i            <= {31'(rand_bits(31)), 1'b0};
        is_compressed_i <= 1'(rand_bits(1));
        predict_taken_i <= 1'(rand_bits(1));
        trans_id_i      <= 3'(rand_bits(3));
    endtask

    task automatic idle_cycle(input logic flush, input logic commit);
        @(posedge clk_i);
        alu_valid_i    <= 1'b0;
        branch_valid_i <= 1'b0;
        csr_valid_i    <= 1'b0;
        mult_valid_i   <= 1'b0;
        flush_i        <= flush;
        csr_commit_i   <= commit;
    endtask

    task automatic wait_ready();
        @(negedge clk_i);
        while (!flu_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        int          j;
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        alu_valid_i     = 1'b0;
        branch_valid_i  = 1'b0;
        csr_valid_i     = 1'b0;
        mult_valid_i    = 1'b0;
        csr_commit_i    = 1'b0;
        is_compressed_i = 1'b0;
        predict_taken_i = 1'b0;
        operator_i      = ADD;
        operand_a_i     = '0;
        operand_b_i     = '0;
        imm_i           = '0;
        pc_i            = '0;
        trans_id_i      = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (i = 0; i < N_ALU; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            issue_op(K_ALU, fu_op_e'(5'(rand_bits(4) % 10)), a, b);
        end
        // Equal operands a quarter of the time, so EQ and GE get hits
        for (i = 0; i < N_BRANCH; i++) begin
            a = rand_bits(32);
            b = (rand_bits(2) == 0) ? a : rand_bits(32);
            issue_op(K_BRANCH, fu_op_e'(5'(10 + rand_bits(3) % 6)), a, b);
        end
        // Back-to-back multiplies, a gap before anything else
        for (i = 0; i < N_MULT_ROUNDS; i++) begin
            for (j = 0; j < 3; j++) begin
                a = rand_bits(32);
                b = rand_bits(32);
                issue_op(K_MULT, fu_op_e'(5'(16 + (i + j) % 3)), a, b);
            end
            idle_cycle(1'b0, 1'b0);
        end

        // CSR held until commit
        wait_ready();
        issue_op(K_CSR, CSR_RW, rand_bits(32), rand_bits(32));
        idle_cycle(1'b0, 1'b0);
        idle_cycle(1'b0, 1'b0);
        idle_cycle(1'b0, 1'b1);
        idle_cycle(1'b0, 1'b0);
        wait_ready();

        // Flush right behind a multiply, then while the CSR entry is full
        issue_op(K_MULT, MULHU, rand_bits(32), rand_bits(32));
        idle_cycle(1'b1, 1'b0);
        idle_cycle(1'b0, 1'b0);
        wait_ready();
        issue_op(K_CSR, CSR_RW, rand_bits(32), rand_bits(32));
        idle_cycle(1'b0, 1'b0);
        idle_cycle(1'b1, 1'b0);
        idle_cycle(1'b0, 1'b0);
        wait_ready();

        repeat (3) idle_cycle(1'b0, 1'b0);
        @(negedge clk_i);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/flu_pkg.sv
source/flu_alu.sv
source/flu_branch_unit.sv
source/flu_mult.sv
source/flu_csr_buffer.sv
source/flu_top.sv
bench/flu_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the fixed-latency unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module flu_tb -f build.f --Mdir obj_dir -o flu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/flu_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- source/flu_alu.sv
/*
 * Single-cycle ALU
 * Add, subtract, logic, shifts and set-less-than, plus the
 * comparison result used by the branch unit
 */

`timescale 1ns/1ps
`default_nettype none

module flu_alu import flu_pkg::*; (
    input  fu_op_e          operator_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  operand_u        operand_b_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_res_o
);

    localparam int unsigned SHAMT_BITS = $clog2(XLEN);

    logic [XLEN-1:0]       b_data;
    logic [XLEN-1:0]       sum;
    logic [XLEN:0]         diff;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  equal;
    logic                  less_u;
    logic                  less_s;

    // ----------------------------------------
    // Shared adder and comparator
    // ----------------------------------------
    assign b_data = operand_b_i.data;
    assign sum    = operand_a_i + b_data;
    // Extra bit catches the unsigned borrow
    assign diff   = {1'b0, operand_a_i} - {1'b0, b_data};
    assign equal  = (diff[XLEN-1:0] == '0);
    assign less_u = diff[XLEN];
    // Differing signs decide directly, otherwise the difference sign
    assign less_s = (operand_a_i[XLEN-1] ^ b_data[XLEN-1]) ? operand_a_i[XLEN-1]
                                                            : diff[XLEN-1];
    // Only the low bits of B move the shifter
    assign shamt  = b_data[SHAMT_BITS-1:0];

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        result_o = '0;
        unique case (operator_i)
            ADD:  result_o = sum;
            SUB:  result_o = diff[XLEN-1:0];
            AND:  result_o = operand_a_i & b_data;
            OR:   result_o = operand_a_i | b_data;
            XOR:  result_o = operand_a_i ^ b_data;
            SLL:  result_o = operand_a_i << shamt;
            SRL:  result_o = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
            SLT:  result_o = {{(XLEN-1){1'b0}}, less_s};
            SLTU: result_o = {{(XLEN-1){1'b0}}, less_u};
            default: result_o = '0;
        endcase
    end

    // Branch condition, low for non-branch operators
    always_comb begin
        branch_res_o = 1'b0;
        unique case (operator_i)
            EQ:  branch_res_o = equal;
            NE:  branch_res_o = ~equal;
            LTS: branch_res_o = less_s;
            GES: branch_res_o = ~less_s;
            LTU: branch_res_o = less_u;
            GEU: branch_res_o = ~less_u;
            default: branch_res_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/flu_branch_unit.sv
/*
 * Branch unit
 * Resolves a conditional branch from the ALU comparison and
 * produces target, link address and the mispredict flag
 */

`timescale 1ns/1ps
`default_nettype none

module flu_branch_unit import flu_pkg::*; (
    input  logic            branch_valid_i,
    input  logic            is_compressed_i,
    input  logic            predict_taken_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic            branch_res_i,
    output logic            resolve_o,
    output logic            taken_o,
    output logic            mispredict_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] link_o
);

    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] jump_pc;

    // Compressed instructions are two bytes long
    assign next_pc = pc_i + (is_compressed_i ? XLEN'(2) : XLEN'(4));
    assign jump_pc = pc_i + imm_i;

    // ----------------------------------------
    // Resolution
    // ----------------------------------------
    always_comb begin
        resolve_o    = branch_valid_i;
        taken_o      = branch_valid_i & branch_res_i;
        // Fall through to the next instruction when not taken
        target_o     = taken_o ? jump_pc : next_pc;
        // Return address for the write-back port
        link_o       = next_pc;
        // Predicted direction against the resolved one
        mispredict_o = branch_valid_i & (predict_taken_i != branch_res_i);
    end

endmodule

`default_nettype wire

//--- source/flu_csr_buffer.sv
/*
 * CSR buffer
 * Holds the address of one pending CSR instruction and blocks
 * further issue until it commits or the pipeline flushes
 */

`timescale 1ns/1ps
`default_nettype none

module flu_csr_buffer import flu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     csr_valid_i,
    input  logic                     csr_commit_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_u                 operand_b_i,
    output logic                     ready_o,
    output logic [XLEN-1:0]          result_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     full_d;
    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    always_comb begin
        full_d = full_q;
        if (csr_valid_i) begin
            full_d = 1'b1;
        end
        // Commit or flush empties the entry
        if (csr_commit_i || flush_i) begin
            full_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else begin
            full_q <= full_d;
        end
    end

    // Address captured on issue
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= operand_b_i.csr.csr_addr;
        end
    end

    assign ready_o    = ~full_q;
    // Write-back value of a CSR op is rs1
    assign result_o   = operand_a_i;
    // Bypass in the issue cycle, held value afterwards
    assign csr_addr_o = csr_valid_i ? operand_b_i.csr.csr_addr : addr_q;

    // Single entry, the issuer must wait for ready
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        full_q |-> !csr_valid_i)
        else $error("CSR issued while buffer full");

endmodule

`default_nettype wire

//--- source/flu_mult.sv
/*
 * One-cycle multiplier
 * Registers low, signed high or unsigned high product word
 * together with the issuing transaction ID
 */

`timescale 1ns/1ps
`default_nettype none

module flu_mult import flu_pkg::*; #(
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    input  fu_op_e                   operator_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_u                 operand_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o
);

    logic signed [2*XLEN-1:0] prod_s;
    logic        [2*XLEN-1:0] prod_u;
    logic        [XLEN-1:0]   result_d;
    logic        [XLEN-1:0]   result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic                     valid_q;

    // Full-width products, low word is the same for both
    assign prod_s = $signed(operand_a_i) * $signed(operand_b_i.data);
    assign prod_u = {{XLEN{1'b0}}, operand_a_i} * {{XLEN{1'b0}}, operand_b_i.data};

    always_comb begin
        unique case (operator_i)
            MUL:     result_d = prod_u[XLEN-1:0];
            MULH:    result_d = prod_s[2*XLEN-1:XLEN];
            MULHU:   result_d = prod_u[2*XLEN-1:XLEN];
            default: result_d = '0;
        endcase
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            // Flush kills the product still in flight
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= result_d;
            trans_id_q <= trans_id_i;
        end
    end

    assign result_o   = result_q;
    assign trans_id_o = trans_id_q;
    // No write-back in a flush cycle
    assign valid_o    = valid_q & ~flush_i;

    // Every unflushed multiply writes back on the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i && !flush_i ##1 !flush_i |-> valid_o)
        else $error("multiply result missing one cycle after issue");

    // Write-back only ever follows an issue
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> $past(mult_valid_i))
        else $error("multiply write-back without issue");

endmodule

`default_nettype wire

//--- source/flu_pkg.sv
/*
 * Fixed-latency unit package
 * Word width, CSR address width, the operator encoding shared by
 * the ALU, branch, multiplier and CSR paths, and the operand B union
 */

`default_nettype none

package flu_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Data word width
    localparam int unsigned XLEN          = 32;
    // CSR address field width
    localparam int unsigned CSR_ADDR_BITS = 12;

    // ----------------------------------------
    // Operator encoding
    // ----------------------------------------
    typedef enum logic [4:0] {
        // Arithmetic and logic
        ADD    = 5'd0,
        SUB    = 5'd1,
        AND    = 5'd2,
        OR     = 5'd3,
        XOR    = 5'd4,
        // Shifts
        SLL    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        // Set less than
        SLT    = 5'd8,
        SLTU   = 5'd9,
        // Branch comparisons
        EQ     = 5'd10,
        NE     = 5'd11,
        LTS    = 5'd12,
        GES    = 5'd13,
        LTU    = 5'd14,
        GEU    = 5'd15,
        // Multiplier
        MUL    = 5'd16,
        MULH   = 5'd17,
        MULHU  = 5'd18,
        // CSR access
        CSR_RW = 5'd19
    } fu_op_e;

    // ----------------------------------------
    // Operand B views
    // ----------------------------------------
    // CSR instructions carry the address in the low bits
    typedef struct packed {
        logic [XLEN-CSR_ADDR_BITS-1:0] unused;
        logic [CSR_ADDR_BITS-1:0]      csr_addr;
    } csr_field_t;

    // Same word, seen as data or as a CSR field
    typedef union packed {
        logic [XLEN-1:0] data;
        csr_field_t      csr;
    } operand_u;

endpackage

`default_nettype wire

//--- source/flu_top.sv
/*
 * Fixed-latency unit
 * ALU, branch unit, CSR buffer and multiplier behind one issue
 * port, with a single prioritized write-back port
 */

`timescale 1ns/1ps
`default_nettype none

module flu_top import flu_pkg::*; #(
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Issue port
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  logic                     csr_commit_i,
    input  logic                     is_compressed_i,
    input  logic                     predict_taken_i,
    input  fu_op_e                   operator_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_u                 operand_b_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [XLEN-1:0]          pc_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    // Write-back port
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    // Branch resolution
    output logic                     resolve_branch_o,
    output logic                     branch_taken_o,
    output logic                     mispredict_o,
    output logic [XLEN-1:0]          branch_target_o,
    // CSR
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     alu_en;
    fu_op_e                   alu_operator;
    logic [XLEN-1:0]          alu_operand_a;
    operand_u                 alu_operand_b;
    logic [XLEN-1:0]          alu_result;
    logic                     alu_branch_res;
    logic [XLEN-1:0]          branch_link;
    fu_op_e                   mult_operator;
    logic [XLEN-1:0]          mult_operand_a;
    operand_u                 mult_operand_b;
    logic [XLEN-1:0]          mult_result;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;
    logic                     csr_ready;
    logic [XLEN-1:0]          csr_result;

    // ----------------------------------------
    // ALU and branch unit, combinational
    // ----------------------------------------
    // Silence the ALU unless it is in use
    assign alu_en        = alu_valid_i | branch_valid_i;
    assign alu_operator  = alu_en ? operator_i  : ADD;
    assign alu_operand_a = alu_en ? operand_a_i : '0;
    assign alu_operand_b = alu_en ? operand_b_i : '0;

    flu_alu alu_i (
        .operator_i   (alu_operator),
        .operand_a_i  (alu_operand_a),
        .operand_b_i  (alu_operand_b),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Branch resolution on the raw issue fields
    flu_branch_unit branch_unit_i (
        .branch_valid_i  (branch_valid_i),
        .is_compressed_i (is_compressed_i),
        .predict_taken_i (predict_taken_i),
        .pc_i            (pc_i),
        .imm_i           (imm_i),
        .branch_res_i    (alu_branch_res),
        .resolve_o       (resolve_branch_o),
        .taken_o         (branch_taken_o),
        .mispredict_o    (mispredict_o),
        .target_o        (branch_target_o),
        .link_o          (branch_link)
    );

    // ----------------------------------------
    // CSR buffer and multiplier
    // ----------------------------------------
    flu_csr_buffer csr_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .ready_o      (csr_ready),
        .result_o     (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    // Multiplier inputs stay quiet between issues
    assign mult_operator  = mult_valid_i ? operator_i  : MUL;
    assign mult_operand_a = mult_valid_i ? operand_a_i : '0;
    assign mult_operand_b = mult_valid_i ? operand_b_i : '0;

    flu_mult #(
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) mult_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .operator_i   (mult_operator),
        .operand_a_i  (mult_operand_a),
        .operand_b_i  (mult_operand_b),
        .trans_id_i   (trans_id_i),
        .result_o     (mult_result),
        .valid_o      (mult_valid),
        .trans_id_o   (mult_trans_id)
    );

    // ----------------------------------------
    // Write-back arbitration
    // ----------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    always_comb begin
        // Link address by default
        flu_result_o   = branch_link;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            // Multiplier returns its own transaction
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    // Single-cycle ops must not meet a multiply on the write-back port
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("write-back collision with multiplier");

endmodule

`default_nettype wire
